/* Bender.yml */
package:
  name: rv_pipe

sources:
  - hw/rv_pipe_pkg.sv
  - hw/rv_pipe_if.sv
  - hw/dec_exe_reg.sv
  - hw/mem_request_gen.sv
  - hw/wb_select.sv
  - hw/exe_mem_reg.sv
  - hw/mem_wb_reg.sv
  - hw/rv_pipe_top.sv
  - target: test
    files:
      - tb/rv_pipe_checks.sv
      - tb/rv_pipe_tb.sv

/* hw/dec_exe_reg.sv */
module dec_exe_reg (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  stall_i,
    input  logic                  dec_valid_i,
    input  rv_pipe_pkg::word_t    dec_instr_i,
    input  rv_pipe_pkg::word_t    dec_pc_i,
    input  rv_pipe_pkg::word_t    dec_rs1_i,
    input  rv_pipe_pkg::word_t    dec_rs2_i,
    input  logic                  dec_mem_read_i,
    input  logic                  dec_mem_write_i,
    input  rv_pipe_pkg::mar_sel_t dec_mar_sel_i,
    input  rv_pipe_pkg::wb_sel_t  dec_wb_sel_i,
    output logic                  exe_valid_o,
    output rv_pipe_pkg::word_t    exe_pc_o,
    output rv_pipe_pkg::word_t    exe_rs1_o,
    output rv_pipe_pkg::word_t    exe_rs2_o,
    output logic                  exe_mem_read_o,
    output logic                  exe_mem_write_o,
    output rv_pipe_pkg::mar_sel_t exe_mar_sel_o,
    output rv_pipe_pkg::wb_sel_t  exe_wb_sel_o,
    output rv_pipe_pkg::funct3_t  exe_funct3_o,
    output rv_pipe_pkg::reg_idx_t exe_rd_o,
    output rv_pipe_pkg::word_t    exe_u_imm_o
);
    import rv_pipe_pkg::*;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            exe_valid_o <= 1'b0;
        end else if (!stall_i) begin
            exe_valid_o <= dec_valid_i;
        end
    end

    // payload only moves with a valid item, bubbles keep the old fields
    always_ff @(posedge clk) begin
        if (!stall_i && dec_valid_i) begin
            exe_pc_o        <= dec_pc_i;
            exe_rs1_o       <= dec_rs1_i;
            exe_rs2_o       <= dec_rs2_i;
            exe_mem_read_o  <= dec_mem_read_i;
            exe_mem_write_o <= dec_mem_write_i;
            exe_mar_sel_o   <= dec_mar_sel_i;
            exe_wb_sel_o    <= dec_wb_sel_i;
            // instruction fields decoded here
            exe_funct3_o    <= funct3_t'(dec_instr_i[14:12]);
            exe_rd_o        <= dec_instr_i[11:7];
            exe_u_imm_o     <= {dec_instr_i[31:12], 12'b0};
        end
    end

endmodule

/* hw/exe_mem_reg.sv */
module exe_mem_reg #(
    parameter rv_pipe_pkg::word_t RESET_PC = rv_pipe_pkg::DEFAULT_RESET_PC
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  stall_i,
    input  logic                  exe_valid_i,
    input  rv_pipe_pkg::word_t    exe_pc_i,
    input  rv_pipe_pkg::word_t    exe_rs2_i,
    input  logic                  exe_mem_read_i,
    input  logic                  exe_mem_write_i,
    input  rv_pipe_pkg::mar_sel_t exe_mar_sel_i,
    input  rv_pipe_pkg::wb_sel_t  exe_wb_sel_i,
    input  rv_pipe_pkg::funct3_t  exe_funct3_i,
    input  rv_pipe_pkg::reg_idx_t exe_rd_i,
    input  rv_pipe_pkg::word_t    exe_u_imm_i,
    input  rv_pipe_pkg::word_t    alu_out_i,
    input  logic                  br_en_i,
    output rv_pipe_pkg::word_t    dmem_addr_o,
    output rv_pipe_pkg::word_t    dmem_wdata_o,
    output rv_pipe_pkg::mask_t    dmem_be_o,
    output logic                  dmem_read_o,
    output logic                  dmem_write_o,
    output logic                  mem_valid_o,
    wb_bundle_if.src              wb_o
);
    import rv_pipe_pkg::*;

    logic    advance;
    logic    mem_op;
    logic    valid_q;
    offset_t offset_d;

    mem_req_if req_if (.clk(clk), .rst(rst));

    assign advance = !stall_i;

    // read/write qualified by the upstream valid so bubbles issue nothing
    assign req_if.mem_read  = exe_valid_i & exe_mem_read_i;
    assign req_if.mem_write = exe_valid_i & exe_mem_write_i;
    assign req_if.funct3    = exe_funct3_i;
    assign req_if.mar_sel   = exe_mar_sel_i;
    assign req_if.pc        = exe_pc_i;
    assign req_if.alu_out   = alu_out_i;
    assign req_if.rs2       = exe_rs2_i;

    mem_request_gen u_req_gen (
        .req_io (req_if)
    );

    assign mem_op = req_if.mem_read | req_if.mem_write;

    // byte offset kept for load extraction in writeback
    assign offset_d = (exe_mar_sel_i == MAR_PC) ? exe_pc_i[1:0] : alu_out_i[1:0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q      <= 1'b0;
            dmem_read_o  <= 1'b0;
            dmem_write_o <= 1'b0;
            dmem_be_o    <= '0;
        end else if (advance) begin
            valid_q      <= exe_valid_i;
            dmem_read_o  <= req_if.mem_read;
            dmem_write_o <= req_if.mem_write;
            if (mem_op) begin
                dmem_be_o <= req_if.byte_en;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance && mem_op) begin
            dmem_addr_o  <= req_if.addr;
            dmem_wdata_o <= req_if.wdata;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_o.pc <= RESET_PC;
        end else if (advance && exe_valid_i) begin
            wb_o.pc <= exe_pc_i;
        end
    end

    always_ff @(posedge clk) begin
        if (advance && exe_valid_i) begin
            wb_o.u_imm   <= exe_u_imm_i;
            wb_o.alu_out <= alu_out_i;
            wb_o.br_en   <= br_en_i;
            wb_o.wb_sel  <= exe_wb_sel_i;
            wb_o.funct3  <= exe_funct3_i;
            wb_o.offset  <= offset_d;
            wb_o.rd      <= exe_rd_i;
        end
    end

    assign wb_o.valid  = valid_q;
    assign mem_valid_o = valid_q;

    // a pending request always names at least one lane
    a_req_has_mask: assert property (
        @(posedge clk) disable iff (rst)
        (dmem_read_o || dmem_write_o) |-> (dmem_be_o != '0)
    );

endmodule

/* hw/mem_request_gen.sv */
module mem_request_gen (
    mem_req_if.gen req_io
);
    import rv_pipe_pkg::*;

    word_t   raw_addr;
    offset_t offset;

    assign raw_addr = (req_io.mar_sel == MAR_PC) ? req_io.pc : req_io.alu_out;
    assign offset   = raw_addr[1:0];

    // cache sees word addresses only
    assign req_io.addr = {raw_addr[XLEN-1:2], 2'b00};

    // store data moved into its byte lane
    assign req_io.wdata = req_io.rs2 << {offset, 3'b000};

    always_comb begin
        case (req_io.funct3)
            FN_W:        req_io.byte_en = 4'b1111;
            FN_H, FN_HU: req_io.byte_en = 4'b0011 << offset;
            FN_B, FN_BU: req_io.byte_en = 4'b0001 << offset;
            default:     req_io.byte_en = '0;
        endcase
    end

    // decode never issues a load and a store together
    a_rd_wr_exclusive: assert property (
        @(posedge req_io.clk) disable iff (req_io.rst)
        !(req_io.mem_read && req_io.mem_write)
    );

    // misaligned halves would straddle lanes
    a_half_aligned: assert property (
        @(posedge req_io.clk) disable iff (req_io.rst)
        (req_io.mem_read || req_io.mem_write) && (req_io.funct3 inside {FN_H, FN_HU})
        |-> !offset[0]
    );

endmodule

/* hw/mem_wb_reg.sv */
module mem_wb_reg #(
    parameter rv_pipe_pkg::word_t RESET_PC = rv_pipe_pkg::DEFAULT_RESET_PC
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  stall_i,
    wb_bundle_if.dst              wb_i,
    input  rv_pipe_pkg::word_t    dmem_rdata_i,
    output logic                  wb_valid_o,
    output rv_pipe_pkg::reg_idx_t wb_rd_o,
    output rv_pipe_pkg::word_t    wb_data_o
);
    import rv_pipe_pkg::*;

    logic    capture;
    word_t   pc_q;
    word_t   u_imm_q;
    word_t   alu_out_q;
    word_t   rdata_q;
    logic    br_en_q;
    wb_sel_t wb_sel_q;
    funct3_t funct3_q;
    offset_t offset_q;

    assign capture = !stall_i && wb_i.valid;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_valid_o <= 1'b0;
            pc_q       <= RESET_PC;
        end else if (!stall_i) begin
            wb_valid_o <= wb_i.valid;
            if (wb_i.valid) begin
                pc_q <= wb_i.pc;
            end
        end
    end

    // cache read data is sampled on the same edge as the bundle
    always_ff @(posedge clk) begin
        if (capture) begin
            u_imm_q   <= wb_i.u_imm;
            alu_out_q <= wb_i.alu_out;
            rdata_q   <= dmem_rdata_i;
            br_en_q   <= wb_i.br_en;
            wb_sel_q  <= wb_i.wb_sel;
            funct3_q  <= wb_i.funct3;
            offset_q  <= wb_i.offset;
            wb_rd_o   <= wb_i.rd;
        end
    end

    wb_select u_wb_select (
        .wb_sel_i  (wb_sel_q),
        .funct3_i  (funct3_q),
        .offset_i  (offset_q),
        .rdata_i   (rdata_q),
        .alu_out_i (alu_out_q),
        .u_imm_i   (u_imm_q),
        .pc_i      (pc_q),
        .br_en_i   (br_en_q),
        .data_o    (wb_data_o)
    );

    // upstream stages are empty out of reset, so nothing can retire yet
    a_no_wb_after_reset: assert property (
        @(posedge clk) $fell(rst) |=> !wb_valid_o
    );

endmodule

/* hw/rv_pipe_if.sv */
// execute-side cache request, combinational within one cycle
interface mem_req_if (
    input logic clk,
    input logic rst
);
    import rv_pipe_pkg::*;

    logic     mem_read;
    logic     mem_write;
    funct3_t  funct3;
    mar_sel_t mar_sel;
    word_t    pc;
    word_t    alu_out;
    word_t    rs2;
    word_t    addr;
    mask_t    byte_en;
    word_t    wdata;

    modport owner (output mem_read, mem_write, funct3, mar_sel, pc, alu_out, rs2,
                   input addr, byte_en, wdata);

    modport gen (input clk, rst, mem_read, mem_write, funct3, mar_sel, pc, alu_out, rs2,
                 output addr, byte_en, wdata);

endinterface

// fields handed from the memory stage to writeback
interface wb_bundle_if;
    import rv_pipe_pkg::*;

    logic     valid;
    word_t    pc;
    word_t    u_imm;
    word_t    alu_out;
    logic     br_en;
    wb_sel_t  wb_sel;
    funct3_t  funct3;
    offset_t  offset;
    reg_idx_t rd;

    modport src (output valid, pc, u_imm, alu_out, br_en, wb_sel, funct3, offset, rd);
    modport dst (input valid, pc, u_imm, alu_out, br_en, wb_sel, funct3, offset, rd);

endinterface

/* hw/rv_pipe_pkg.sv */
package rv_pipe_pkg;

    // datapath width
    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;

    // one enable bit per byte lane
    typedef logic [XLEN/8-1:0] mask_t;

    typedef logic [1:0] offset_t;
    typedef logic [4:0] reg_idx_t;

    // load/store width, straight from instr[14:12]
    typedef enum logic [2:0] {
        FN_B  = 3'd0,
        FN_H  = 3'd1,
        FN_W  = 3'd2,
        FN_BU = 3'd4,
        FN_HU = 3'd5
    } funct3_t;

    // data cache address source
    typedef enum logic {
        MAR_PC  = 1'b0,
        MAR_ALU = 1'b1
    } mar_sel_t;

    // register file write source
    typedef enum logic [2:0] {
        WB_ALU  = 3'd0,
        WB_MEM  = 3'd1,
        WB_UIMM = 3'd2,
        WB_PC4  = 3'd3,
        WB_BR   = 3'd4
    } wb_sel_t;

    // boot address of the core
    localparam word_t DEFAULT_RESET_PC = 32'h4000_0000;

endpackage

/* hw/rv_pipe_top.sv */
module rv_pipe_top #(
    parameter rv_pipe_pkg::word_t RESET_PC = rv_pipe_pkg::DEFAULT_RESET_PC
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  stall_i,
    input  logic                  dec_valid_i,
    input  rv_pipe_pkg::word_t    dec_instr_i,
    input  rv_pipe_pkg::word_t    dec_pc_i,
    input  rv_pipe_pkg::word_t    dec_rs1_i,
    input  rv_pipe_pkg::word_t    dec_rs2_i,
    input  logic                  dec_mem_read_i,
    input  logic                  dec_mem_write_i,
    input  rv_pipe_pkg::mar_sel_t dec_mar_sel_i,
    input  rv_pipe_pkg::wb_sel_t  dec_wb_sel_i,
    input  rv_pipe_pkg::word_t    alu_out_i,
    input  logic                  br_en_i,
    input  rv_pipe_pkg::word_t    dmem_rdata_i,
    output logic                  exe_valid_o,
    output rv_pipe_pkg::word_t    exe_pc_o,
    output rv_pipe_pkg::word_t    exe_rs1_o,
    output rv_pipe_pkg::word_t    exe_rs2_o,
    output rv_pipe_pkg::word_t    dmem_addr_o,
    output rv_pipe_pkg::word_t    dmem_wdata_o,
    output rv_pipe_pkg::mask_t    dmem_be_o,
    output logic                  dmem_read_o,
    output logic                  dmem_write_o,
    output logic                  mem_valid_o,
    output logic                  wb_valid_o,
    output rv_pipe_pkg::reg_idx_t wb_rd_o,
    output rv_pipe_pkg::word_t    wb_data_o
);
    import rv_pipe_pkg::*;

    // decode/execute fields that stay internal
    logic     exe_mem_read;
    logic     exe_mem_write;
    mar_sel_t exe_mar_sel;
    wb_sel_t  exe_wb_sel;
    funct3_t  exe_funct3;
    reg_idx_t exe_rd;
    word_t    exe_u_imm;

    wb_bundle_if wb_bus ();

    dec_exe_reg u_dec_exe (
        .clk             (clk),
        .rst             (rst),
        .stall_i         (stall_i),
        .dec_valid_i     (dec_valid_i),
        .dec_instr_i     (dec_instr_i),
        .dec_pc_i        (dec_pc_i),
        .dec_rs1_i       (dec_rs1_i),
        .dec_rs2_i       (dec_rs2_i),
        .dec_mem_read_i  (dec_mem_read_i),
        .dec_mem_write_i (dec_mem_write_i),
        .dec_mar_sel_i   (dec_mar_sel_i),
        .dec_wb_sel_i    (dec_wb_sel_i),
        .exe_valid_o     (exe_valid_o),
        .exe_pc_o        (exe_pc_o),
        .exe_rs1_o       (exe_rs1_o),
        .exe_rs2_o       (exe_rs2_o),
        .exe_mem_read_o  (exe_mem_read),
        .exe_mem_write_o (exe_mem_write),
        .exe_mar_sel_o   (exe_mar_sel),
        .exe_wb_sel_o    (exe_wb_sel),
        .exe_funct3_o    (exe_funct3),
        .exe_rd_o        (exe_rd),
        .exe_u_imm_o     (exe_u_imm)
    );

    exe_mem_reg #(
        .RESET_PC (RESET_PC)
    ) u_exe_mem (
        .clk             (clk),
        .rst             (rst),
        .stall_i         (stall_i),
        .exe_valid_i     (exe_valid_o),
        .exe_pc_i        (exe_pc_o),
        .exe_rs2_i       (exe_rs2_o),
        .exe_mem_read_i  (exe_mem_read),
        .exe_mem_write_i (exe_mem_write),
        .exe_mar_sel_i   (exe_mar_sel),
        .exe_wb_sel_i    (exe_wb_sel),
        .exe_funct3_i    (exe_funct3),
        .exe_rd_i        (exe_rd),
        .exe_u_imm_i     (exe_u_imm),
        .alu_out_i       (alu_out_i),
        .br_en_i         (br_en_i),
        .dmem_addr_o     (dmem_addr_o),
        .dmem_wdata_o    (dmem_wdata_o),
        .dmem_be_o       (dmem_be_o),
        .dmem_read_o     (dmem_read_o),
        .dmem_write_o    (dmem_write_o),
        .mem_valid_o     (mem_valid_o),
        .wb_o            (wb_bus)
    );

    mem_wb_reg #(
        .RESET_PC (RESET_PC)
    ) u_mem_wb (
        .clk          (clk),
        .rst          (rst),
        .stall_i      (stall_i),
        .wb_i         (wb_bus),
        .dmem_rdata_i (dmem_rdata_i),
        .wb_valid_o   (wb_valid_o),
        .wb_rd_o      (wb_rd_o),
        .wb_data_o    (wb_data_o)
    );

endmodule

/* hw/wb_select.sv */
module wb_select (
    input  rv_pipe_pkg::wb_sel_t wb_sel_i,
    input  rv_pipe_pkg::funct3_t funct3_i,
    input  rv_pipe_pkg::offset_t offset_i,
    input  rv_pipe_pkg::word_t   rdata_i,
    input  rv_pipe_pkg::word_t   alu_out_i,
    input  rv_pipe_pkg::word_t   u_imm_i,
    input  rv_pipe_pkg::word_t   pc_i,
    input  logic                 br_en_i,
    output rv_pipe_pkg::word_t   data_o
);
    import rv_pipe_pkg::*;

    word_t shifted;
    word_t load_data;

    // addressed byte or half brought down to lane 0
    assign shifted = rdata_i >> {offset_i, 3'b000};

    always_comb begin
        case (funct3_i)
            FN_B:    load_data = {{(XLEN-8){shifted[7]}}, shifted[7:0]};
            FN_BU:   load_data = {{(XLEN-8){1'b0}}, shifted[7:0]};
            FN_H:    load_data = {{(XLEN-16){shifted[15]}}, shifted[15:0]};
            FN_HU:   load_data = {{(XLEN-16){1'b0}}, shifted[15:0]};
            default: load_data = rdata_i;
        endcase
    end

    always_comb begin
        case (wb_sel_i)
            WB_MEM:  data_o = load_data;
            WB_UIMM: data_o = u_imm_i;
            WB_PC4:  data_o = pc_i + 32'd4;
            // slt-style results
            WB_BR:   data_o = {{(XLEN-1){1'b0}}, br_en_i};
            default: data_o = alu_out_i;
        endcase
    end

endmodule

/* sim.f */
hw/rv_pipe_pkg.sv
hw/rv_pipe_if.sv
hw/dec_exe_reg.sv
hw/mem_request_gen.sv
hw/wb_select.sv
hw/exe_mem_reg.sv
hw/mem_wb_reg.sv
hw/rv_pipe_top.sv
tb/rv_pipe_checks.sv
tb/rv_pipe_tb.sv

/* tb/rv_pipe_checks.sv */
module rv_pipe_checks (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  stall_i,
    input  logic                  dec_valid_i,
    input  rv_pipe_pkg::word_t    dec_pc_i,
    input  rv_pipe_pkg::word_t    dec_rs1_i,
    input  rv_pipe_pkg::word_t    dec_rs2_i,
    input  logic                  exe_valid_i,
    input  rv_pipe_pkg::word_t    exe_pc_i,
    input  rv_pipe_pkg::word_t    exe_rs1_i,
    input  rv_pipe_pkg::word_t    exe_rs2_i,
    input  rv_pipe_pkg::word_t    dmem_addr_i,
    input  rv_pipe_pkg::word_t    dmem_wdata_i,
    input  rv_pipe_pkg::mask_t    dmem_be_i,
    input  logic                  dmem_read_i,
    input  logic                  dmem_write_i,
    input  logic                  mem_valid_i,
    input  logic                  wb_valid_i,
    input  rv_pipe_pkg::reg_idx_t wb_rd_i,
    input  rv_pipe_pkg::word_t    wb_data_i,
    output logic                  err_o
);
    initial err_o = 1'b0;

    // everything idle while reset is held
    c_reset_idle: assert property (@(posedge clk)
        rst |-> !exe_valid_i && !mem_valid_i && !wb_valid_i && !dmem_read_i
            && !dmem_write_i && dmem_be_i == '0)
    else begin
        $display("outputs not idle during reset");
        err_o = 1'b1;
    end

    c_exe_capture: assert property (@(posedge clk) disable iff (rst)
        (!stall_i && dec_valid_i) |=> exe_valid_i && exe_pc_i == $past(dec_pc_i)
            && exe_rs1_i == $past(dec_rs1_i) && exe_rs2_i == $past(dec_rs2_i))
    else begin
        $display("execute outputs do not match the captured decode item");
        err_o = 1'b1;
    end

    // a stalled edge freezes every output
    c_stall_hold: assert property (@(posedge clk) disable iff (rst)
        stall_i |=> $stable(exe_valid_i) && $stable(exe_pc_i) && $stable(exe_rs1_i)
            && $stable(exe_rs2_i) && $stable(dmem_addr_i) && $stable(dmem_wdata_i)
            && $stable(dmem_be_i) && $stable(dmem_read_i) && $stable(dmem_write_i)
            && $stable(mem_valid_i) && $stable(wb_valid_i) && $stable(wb_rd_i)
            && $stable(wb_data_i))
    else begin
        $display("an output changed while stalled");
        err_o = 1'b1;
    end

    c_bubble_exe: assert property (@(posedge clk) disable iff (rst)
        (!stall_i && !dec_valid_i) |=> !exe_valid_i)
    else begin
        $display("bubble did not reach execute");
        err_o = 1'b1;
    end

    c_bubble_mem: assert property (@(posedge clk) disable iff (rst)
        (!stall_i && !exe_valid_i) |=> !mem_valid_i && !dmem_read_i && !dmem_write_i)
    else begin
        $display("bubble issued a cache request");
        err_o = 1'b1;
    end

    c_bubble_wb: assert property (@(posedge clk) disable iff (rst)
        (!stall_i && !mem_valid_i) |=> !wb_valid_i)
    else begin
        $display("bubble retired as a valid writeback");
        err_o = 1'b1;
    end

endmodule

/* tb/rv_pipe_tb.sv */
module rv_pipe_tb;
    import rv_pipe_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int N_INSTR    = 300;

    logic     clk;
    logic     rst;
    logic     stall_i;
    logic     dec_valid_i;
    word_t    dec_instr_i;
    word_t    dec_pc_i;
    word_t    dec_rs1_i;
    word_t    dec_rs2_i;
    logic     dec_mem_read_i;
    logic     dec_mem_write_i;
    mar_sel_t dec_mar_sel_i;
    wb_sel_t  dec_wb_sel_i;
    word_t    alu_out_i;
    logic     br_en_i;
    word_t    dmem_rdata_i;
    logic     exe_valid_o;
    word_t    exe_pc_o;
    word_t    exe_rs1_o;
    word_t    exe_rs2_o;
    word_t    dmem_addr_o;
    word_t    dmem_wdata_o;
    mask_t    dmem_be_o;
    logic     dmem_read_o;
    logic     dmem_write_o;
    logic     mem_valid_o;
    logic     wb_valid_o;
    reg_idx_t wb_rd_o;
    word_t    wb_data_o;
    logic     chk_err;

    // per-instruction stimulus, indexed by issue order
    word_t    alu_val [N_INSTR];
    logic     br_val [N_INSTR];
    word_t    wb_data_q[$];
    reg_idx_t wb_rd_q[$];
    // expected cache requests in issue order
    logic     req_rd_q[$];
    word_t    req_addr_q[$];
    word_t    req_data_q[$];
    mask_t    req_be_q[$];

    rv_pipe_top uut (.*);

    rv_pipe_checks u_checks (
        .clk (clk), .rst (rst), .stall_i (stall_i), .dec_valid_i (dec_valid_i),
        .dec_pc_i (dec_pc_i), .dec_rs1_i (dec_rs1_i), .dec_rs2_i (dec_rs2_i),
        .exe_valid_i (exe_valid_o), .exe_pc_i (exe_pc_o), .exe_rs1_i (exe_rs1_o),
        .exe_rs2_i (exe_rs2_o), .dmem_addr_i (dmem_addr_o), .dmem_wdata_i (dmem_wdata_o),
        .dmem_be_i (dmem_be_o), .dmem_read_i (dmem_read_o), .dmem_write_i (dmem_write_o),
        .mem_valid_i (mem_valid_o), .wb_valid_i (wb_valid_o), .wb_rd_i (wb_rd_o),
        .wb_data_i (wb_data_o), .err_o (chk_err)
    );

    // cache model
    assign dmem_rdata_i = dmem_addr_o ^ 32'hA5A5_5A5A;

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic report_mismatch(input string name, input word_t exp, input word_t act);
        $display("MISMATCH %s expected %h actual %h", name, exp, act);
        $display("Checks failed");
        $fatal(1, "stopping at first error");
    endtask

    always @(posedge chk_err) begin
        $display("Checks failed");
        $fatal(1, "checker assertion fired");
    end

    initial begin
        #(20 * N_INSTR * CLK_PERIOD);
        $display("Checks failed");
        $fatal(1, "watchdog expired before the pipeline drained");
    end

    // compare retiring items where outputs are stable
    always @(negedge clk) begin
        if (!rst && !stall_i && wb_valid_o) begin
            assert (wb_data_q.size() > 0) else begin
                $display("writeback with no expected item");
                $display("Checks failed");
                $fatal(1, "unexpected writeback");
            end
            assert (wb_data_o === wb_data_q[0])
                else report_mismatch("wb_data", wb_data_q[0], wb_data_o);
            assert (wb_rd_o === wb_rd_q[0])
                else report_mismatch("wb_rd", word_t'(wb_rd_q[0]), word_t'(wb_rd_o));
            void'(wb_data_q.pop_front());
            void'(wb_rd_q.pop_front());
        end
        if (!rst && !stall_i && (dmem_read_o || dmem_write_o)) begin
            assert (req_addr_q.size() > 0) else begin
                $display("cache request with no expected access");
                $display("Checks failed");
                $fatal(1, "unexpected cache request");
            end
            assert (dmem_read_o === req_rd_q[0] && dmem_write_o === !req_rd_q[0])
                else report_mismatch("mem_kind", word_t'({req_rd_q[0], !req_rd_q[0]}),
                                     word_t'({dmem_read_o, dmem_write_o}));
            assert (dmem_addr_o === req_addr_q[0])
                else report_mismatch("mem_addr", req_addr_q[0], dmem_addr_o);
            assert (dmem_be_o === req_be_q[0])
                else report_mismatch("mem_be", word_t'(req_be_q[0]), word_t'(dmem_be_o));
            if (dmem_write_o) begin
                assert (dmem_wdata_o === req_data_q[0])
                    else report_mismatch("store_data", req_data_q[0], dmem_wdata_o);
            end
            void'(req_rd_q.pop_front());
            void'(req_addr_q.pop_front());
            void'(req_be_q.pop_front());
            void'(req_data_q.pop_front());
        end
    end

    // builds one random instruction and queues its expected results
    task automatic issue_item(input int id);
        int       kind;
        int       f3;
        logic [1:0] off;
        word_t    raw;
        word_t    pc;
        word_t    instr;
        word_t    rs2;
        word_t    rdata;
        word_t    sh;
        word_t    exp;
        mar_sel_t msel;
        wb_sel_t  wsel;
        kind = $urandom % 6;
        f3   = $urandom % 8;
        off  = $urandom % 4;
        if (kind == 4) begin
            f3 = (int'($urandom % 5) < 3) ? int'($urandom % 3) : 4 + int'($urandom % 2);
        end else if (kind == 5) begin
            f3 = $urandom % 3;
        end
        // keep memory accesses naturally aligned
        if (kind >= 4 && f3 == 2) off = 2'b00;
        if (kind >= 4 && (f3 == 1 || f3 == 5)) off[0] = 1'b0;
        msel = mar_sel_t'($urandom % 2);
        pc   = $urandom;
        alu_val[id] = $urandom;
        br_val[id]  = $urandom % 2;
        if (msel == MAR_PC) pc[1:0] = off;
        else alu_val[id][1:0] = off;
        raw   = (msel == MAR_PC) ? pc : alu_val[id];
        rs2   = $urandom;
        instr = {17'($urandom), 3'(f3), 5'($urandom), 7'h33};
        case (kind)
            1:       wsel = WB_UIMM;
            2:       wsel = WB_PC4;
            3:       wsel = WB_BR;
            4:       wsel = WB_MEM;
            default: wsel = WB_ALU;
        endcase
        case (wsel)
            WB_UIMM: exp = {instr[31:12], 12'h000};
            WB_PC4:  exp = pc + 4;
            WB_BR:   exp = {31'd0, br_val[id]};
            WB_MEM: begin
                rdata = {raw[31:2], 2'b00} ^ 32'hA5A5_5A5A;
                sh    = rdata >> (8 * off);
                if (f3 == 0) exp = {{24{sh[7]}}, sh[7:0]};
                else if (f3 == 4) exp = {24'd0, sh[7:0]};
                else if (f3 == 1) exp = {{16{sh[15]}}, sh[15:0]};
                else if (f3 == 5) exp = {16'd0, sh[15:0]};
                else exp = rdata;
            end
            default: exp = alu_val[id];
        endcase
        wb_data_q.push_back(exp);
        wb_rd_q.push_back(instr[11:7]);
        if (kind >= 4) begin
            req_rd_q.push_back(kind == 4);
            req_addr_q.push_back({raw[31:2], 2'b00});
            req_be_q.push_back(f3 == 2 ? 4'b1111
                : ((f3 == 1 || f3 == 5) ? 4'b0011 << off : 4'b0001 << off));
            req_data_q.push_back(rs2 << (8 * off));
        end
        dec_valid_i     <= 1'b1;
        dec_instr_i     <= instr;
        dec_pc_i        <= pc;
        dec_rs1_i       <= $urandom;
        dec_rs2_i       <= rs2;
        dec_mem_read_i  <= (kind == 4);
        dec_mem_write_i <= (kind == 5);
        dec_mar_sel_i   <= msel;
        dec_wb_sel_i    <= wsel;
    endtask

    initial begin
        int issued;
        int dec_id;
        int exe_id;
        void'($urandom(11220));
        issued = 0;
        dec_id = -1;
        exe_id = -1;
        rst = 1'b1;
        stall_i = 1'b0;
        dec_valid_i = 1'b0;
        dec_instr_i = '0;
        dec_pc_i = '0;
        dec_rs1_i = '0;
        dec_rs2_i = '0;
        dec_mem_read_i = 1'b0;
        dec_mem_write_i = 1'b0;
        dec_mar_sel_i = MAR_ALU;
        dec_wb_sel_i = WB_ALU;
        alu_out_i = '0;
        br_en_i = 1'b0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        while (issued < N_INSTR || wb_data_q.size() > 0) begin
            @(posedge clk);
            if (!stall_i) begin
                // the presented item moves into execute on this edge
                exe_id = dec_id;
                alu_out_i <= (exe_id >= 0) ? alu_val[exe_id] : word_t'($urandom);
                br_en_i   <= (exe_id >= 0) ? br_val[exe_id] : 1'b0;
                if (issued < N_INSTR && $urandom % 5 != 0) begin
                    issue_item(issued);
                    dec_id = issued;
                    issued++;
                end else begin
                    dec_valid_i <= 1'b0;
                    dec_id = -1;
                end
            end
            stall_i <= ($urandom % 4 == 0);
        end
        repeat (4) @(posedge clk);
        if (req_addr_q.size() == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("Checks failed");
            $fatal(1, "cache requests left unchecked");
        end
    end

endmodule
